// ==== source/accel_cfg_pkg.sv ====
// #########################################################################
// accelerator configuration
// sizes shared by every block: lane count, group size, element and sum
// widths, operand memory depth and the pipeline drain length
// #########################################################################

package accel_cfg_pkg;

  localparam int num_lanes  = 4;    // lanes, one output port each
  localparam int group_size = 4;    // activations per memory word

  localparam int data_width = 8;    // activation, weight, clip bound, output element
  localparam int acc_width  = 16;   // product and accumulated sum, wraps mod 2^16

  localparam int mem_depth  = 256;  // words per operand memory
  localparam int max_reads  = 16;   // largest reads per iteration

  // cycles from the last activation read issue to the last output write:
  // memory read, multiply-accumulate, clip register
  localparam int pipe_drain = 3;

endpackage

// ==== source/accel_types_pkg.sv ====
// #########################################################################
// accelerator types
// vector typedefs built from the configuration sizes, plus the job FSM
// state encoding
// #########################################################################

package accel_types_pkg;

  typedef logic [accel_cfg_pkg::data_width-1:0] elem_t;  // one 8-bit element

  // a memory word holds either one activation group or one weight per lane
  typedef logic [accel_cfg_pkg::group_size*accel_cfg_pkg::data_width-1:0] word_t;

  typedef logic [$clog2(accel_cfg_pkg::mem_depth)-1:0] addr_t;  // wraps at depth
  typedef logic [$clog2(accel_cfg_pkg::mem_depth)-1:0] iter_t;  // one weight word per iter
  typedef logic [$clog2(accel_cfg_pkg::max_reads):0]   slot_t;  // must hold max_reads itself

  typedef logic [accel_cfg_pkg::acc_width-1:0] sum_t;
  typedef logic [accel_cfg_pkg::group_size*accel_cfg_pkg::acc_width-1:0] sum_group_t;

  typedef enum logic [2:0] {
    idle,
    weight_req,   // weight word read issued
    weight_wait,  // weight word on the bus, lanes latch it
    stream,       // one activation read per cycle
    drain         // pipeline empties before busy drops
  } job_state_t;

endpackage

// ==== source/operand_mem.sv ====
// #########################################################################
// operand memory
// mem_depth words, one write port for loading from outside and one
// registered read port with a read-valid strobe
// #########################################################################

module operand_mem (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   write,
  input  accel_types_pkg::addr_t addr_write,
  input  accel_types_pkg::word_t data_write,
  input  logic                   read,
  input  accel_types_pkg::addr_t addr_read,
  output accel_types_pkg::word_t data_read,
  output logic                   valid_out
);

  accel_types_pkg::word_t mem [accel_cfg_pkg::mem_depth];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr_write] <= data_write;
    end
    data_read <= mem[addr_read];  // read every cycle, valid_out qualifies it
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= read;  // data follows the strobe by one cycle
    end
  end

endmodule

// ==== source/job_fsm.sv ====
// #########################################################################
// job sequencer
// accepts a configure pulse when idle, then per iteration fetches one
// weight word and streams the activation reads, drains the pipeline and
// holds busy for the whole job
// #########################################################################

module job_fsm (
  input  logic clk,
  input  logic reset,
  input  logic configure,
  input  logic slot_last,
  input  logic iter_last,
  input  logic drain_done,
  output logic start,
  output logic weight_rd,
  output logic act_rd,
  output logic next_iter,
  output logic drain,
  output logic busy
);

  accel_types_pkg::job_state_t state;
  accel_types_pkg::job_state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= accel_types_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      accel_types_pkg::idle: begin
        if (configure) begin
          state_next = accel_types_pkg::weight_req;
        end
      end
      accel_types_pkg::weight_req:  state_next = accel_types_pkg::weight_wait;
      accel_types_pkg::weight_wait: state_next = accel_types_pkg::stream;
      accel_types_pkg::stream: begin
        // last slot closes the iteration
        if (slot_last) begin
          state_next = iter_last ? accel_types_pkg::drain : accel_types_pkg::weight_req;
        end
      end
      accel_types_pkg::drain: begin
        if (drain_done) begin
          state_next = accel_types_pkg::idle;
        end
      end
      default: state_next = accel_types_pkg::idle;
    endcase
  end

  assign start     = (state == accel_types_pkg::idle) && configure;  // configure ignored when busy
  assign weight_rd = (state == accel_types_pkg::weight_req);
  assign act_rd    = (state == accel_types_pkg::stream);
  assign next_iter = act_rd && slot_last && !iter_last;
  assign drain     = (state == accel_types_pkg::drain);
  assign busy      = (state != accel_types_pkg::idle);  // high from the cycle after start

endmodule

// ==== source/loop_counter.sv ====
// #########################################################################
// loop counters
// running activation and weight addresses, iteration and slot counts,
// first and last iteration tags, and the pipeline drain count
// #########################################################################

module loop_counter (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic                   act_rd,
  input  logic                   next_iter,
  input  logic                   drain,
  input  accel_types_pkg::iter_t num_iters,
  input  accel_types_pkg::slot_t num_reads_per_iter,
  input  accel_types_pkg::addr_t read_address,
  output accel_types_pkg::addr_t act_addr,
  output accel_types_pkg::addr_t weight_addr,
  output accel_types_pkg::slot_t slot,
  output logic                   first_iter,
  output logic                   iter_last,
  output logic                   slot_last,
  output logic                   drain_done
);

  accel_types_pkg::iter_t iters_q;  // job bounds
  accel_types_pkg::slot_t reads_q;
  accel_types_pkg::iter_t iter;

  always_ff @(posedge clk) begin
    if (start) begin
      iters_q <= num_iters;
      reads_q <= num_reads_per_iter;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      act_addr    <= '0;
      weight_addr <= '0;
      iter        <= '0;
      slot        <= '0;
    end else if (start) begin
      act_addr    <= read_address;
      weight_addr <= read_address;
      iter        <= '0;
      slot        <= '0;
    end else begin
      // activations are laid out iteration after iteration, so one running address does
      if (act_rd) begin
        act_addr <= act_addr + 1'b1;
        slot     <= slot_last ? '0 : slot + 1'b1;
      end else if (drain) begin
        slot <= slot + 1'b1;  // slot counter doubles as drain timer
      end
      if (next_iter) begin
        iter        <= iter + 1'b1;
        weight_addr <= weight_addr + 1'b1;  // one weight word per iteration
      end
    end
  end

  assign first_iter = (iter == '0);
  assign iter_last  = (iter == iters_q - 1'b1);
  assign slot_last  = (slot == reads_q - 1'b1);
  assign drain_done = drain && (slot == accel_types_pkg::slot_t'(accel_cfg_pkg::pipe_drain - 1));

endmodule

// ==== source/mac_lane.sv ====
// #########################################################################
// multiply-accumulate lane
// multiplies each activation group by the lane's weight byte and adds the
// products into per-slot sums, emitting them on the last iteration
// #########################################################################

module mac_lane (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        act_valid,
  input  accel_types_pkg::word_t      act_data,
  input  logic                        weight_valid,
  input  accel_types_pkg::elem_t      weight_byte,
  input  accel_types_pkg::slot_t      slot,
  input  logic                        first_iter,
  input  logic                        last_iter,
  output logic                        result,
  output accel_types_pkg::slot_t      result_slot,
  output accel_types_pkg::sum_group_t sums
);

  accel_types_pkg::sum_group_t acc [accel_cfg_pkg::max_reads];  // one group of sums per slot
  accel_types_pkg::sum_group_t acc_next;
  accel_types_pkg::elem_t      weight_q;
  accel_types_pkg::slot_t      slot_d;
  logic                        first_d;
  logic                        last_d;
  logic [$clog2(accel_cfg_pkg::max_reads)-1:0] acc_idx;

  assign acc_idx = slot_d[$clog2(accel_cfg_pkg::max_reads)-1:0];

  // new sums for the slot whose data is on the bus
  always_comb begin
    accel_types_pkg::sum_t base;
    accel_types_pkg::sum_t prod;
    for (int g = 0; g < accel_cfg_pkg::group_size; g++) begin
      base = first_d ? '0 : acc[acc_idx][g*accel_cfg_pkg::acc_width +: accel_cfg_pkg::acc_width];
      prod = accel_types_pkg::sum_t'(act_data[g*accel_cfg_pkg::data_width +:
                                              accel_cfg_pkg::data_width])
           * accel_types_pkg::sum_t'(weight_q);
      acc_next[g*accel_cfg_pkg::acc_width +: accel_cfg_pkg::acc_width] = base + prod;  // wraps
    end
  end

  always_ff @(posedge clk) begin
    if (weight_valid) begin
      weight_q <= weight_byte;  // held until the next iteration's weight arrives
    end
    if (act_valid) begin
      acc[acc_idx] <= acc_next;
    end
    slot_d      <= slot;        // tags travel with the read, one cycle
    result_slot <= slot_d;
    sums        <= acc_next;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      first_d <= 1'b0;
      last_d  <= 1'b0;
      result  <= 1'b0;
    end else begin
      first_d <= first_iter;
      last_d  <= last_iter;
      result  <= act_valid && last_d;  // final sums only
    end
  end

endmodule

// ==== source/output_writer.sv ====
// #########################################################################
// output writer
// clips one lane's final sums into the configured window and registers
// the output word, its address and the write strobe
// #########################################################################

module output_writer (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  accel_types_pkg::addr_t      write_address,
  input  accel_types_pkg::elem_t      min_clip,
  input  accel_types_pkg::elem_t      max_clip,
  input  logic                        result,
  input  accel_types_pkg::slot_t      result_slot,
  input  accel_types_pkg::sum_group_t sums,
  output accel_types_pkg::word_t      data,
  output accel_types_pkg::addr_t      addr,
  output logic                        valid
);

  accel_types_pkg::addr_t base_q;
  accel_types_pkg::elem_t min_q;
  accel_types_pkg::elem_t max_q;
  accel_types_pkg::word_t clipped;

  always_comb begin
    accel_types_pkg::sum_t s;
    for (int g = 0; g < accel_cfg_pkg::group_size; g++) begin
      s = sums[g*accel_cfg_pkg::acc_width +: accel_cfg_pkg::acc_width];
      if (s < accel_types_pkg::sum_t'(min_q)) begin
        clipped[g*accel_cfg_pkg::data_width +: accel_cfg_pkg::data_width] = min_q;
      end else if (s > accel_types_pkg::sum_t'(max_q)) begin
        clipped[g*accel_cfg_pkg::data_width +: accel_cfg_pkg::data_width] = max_q;
      end else begin
        clipped[g*accel_cfg_pkg::data_width +: accel_cfg_pkg::data_width] =
          accel_types_pkg::elem_t'(s);  // in window, low byte is exact
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      base_q <= write_address;
      min_q  <= min_clip;
      max_q  <= max_clip;
    end
    data <= clipped;
    addr <= base_q + accel_types_pkg::addr_t'(result_slot);  // wraps at 256
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else begin
      valid <= result;
    end
  end

endmodule

// ==== source/rtlinf_accel.sv ====
// #########################################################################
// inference accelerator top
// activation and weight memories, job sequencer, loop counters and
// num_lanes multiply-accumulate lanes, each with its own output port
// #########################################################################

module rtlinf_accel (
  input  logic                   clk,
  input  logic                   reset,

  input  logic                   mem_write,           // load one word
  input  logic                   mem_sel,             // 0 activations, 1 weights
  input  accel_types_pkg::addr_t mem_addr,
  input  accel_types_pkg::word_t mem_data,

  input  logic                   configure,           // job start pulse
  input  accel_types_pkg::iter_t num_iters,
  input  accel_types_pkg::slot_t num_reads_per_iter,
  input  accel_types_pkg::addr_t read_address,
  input  accel_types_pkg::addr_t write_address,
  input  accel_types_pkg::elem_t min_clip,
  input  accel_types_pkg::elem_t max_clip,

  output accel_types_pkg::word_t [accel_cfg_pkg::num_lanes-1:0] data,
  output accel_types_pkg::addr_t [accel_cfg_pkg::num_lanes-1:0] addr,
  output logic [accel_cfg_pkg::num_lanes-1:0]                   valid,
  output logic                                                  busy
);

  // sequencer and counter controls
  logic start, weight_rd, act_rd, next_iter, drain;
  logic slot_last, iter_last, drain_done, first_iter;
  accel_types_pkg::slot_t slot;
  accel_types_pkg::addr_t act_addr;
  accel_types_pkg::addr_t weight_addr;

  // memory read data, broadcast to all lanes
  accel_types_pkg::word_t act_word;
  accel_types_pkg::word_t weight_word;
  logic                   act_valid;
  logic                   weight_valid;

  // lane results into the writers
  logic [accel_cfg_pkg::num_lanes-1:0] result;
  accel_types_pkg::slot_t              result_slot [accel_cfg_pkg::num_lanes];
  accel_types_pkg::sum_group_t         lane_sums [accel_cfg_pkg::num_lanes];

  operand_mem act_mem (
    .clk        ( clk                    ),
    .reset      ( reset                  ),
    .write      ( mem_write && !mem_sel  ),
    .addr_write ( mem_addr               ),
    .data_write ( mem_data               ),
    .read       ( act_rd                 ),
    .addr_read  ( act_addr               ),
    .data_read  ( act_word               ),
    .valid_out  ( act_valid              )
  );

  operand_mem weight_mem (
    .clk        ( clk                    ),
    .reset      ( reset                  ),
    .write      ( mem_write && mem_sel   ),
    .addr_write ( mem_addr               ),
    .data_write ( mem_data               ),
    .read       ( weight_rd              ),
    .addr_read  ( weight_addr            ),
    .data_read  ( weight_word            ),
    .valid_out  ( weight_valid           )
  );

  job_fsm i_job_fsm (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .configure  ( configure  ),
    .slot_last  ( slot_last  ),
    .iter_last  ( iter_last  ),
    .drain_done ( drain_done ),
    .start      ( start      ),
    .weight_rd  ( weight_rd  ),
    .act_rd     ( act_rd     ),
    .next_iter  ( next_iter  ),
    .drain      ( drain      ),
    .busy       ( busy       )
  );

  loop_counter i_loop_counter (
    .clk                ( clk                ),
    .reset              ( reset              ),
    .start              ( start              ),
    .act_rd             ( act_rd             ),
    .next_iter          ( next_iter          ),
    .drain              ( drain              ),
    .num_iters          ( num_iters          ),
    .num_reads_per_iter ( num_reads_per_iter ),
    .read_address       ( read_address       ),
    .act_addr           ( act_addr           ),
    .weight_addr        ( weight_addr        ),
    .slot               ( slot               ),
    .first_iter         ( first_iter         ),
    .iter_last          ( iter_last          ),
    .slot_last          ( slot_last          ),
    .drain_done         ( drain_done         )
  );

  for (genvar l = 0; l < accel_cfg_pkg::num_lanes; l++) begin : g_lane
    mac_lane i_mac_lane (
      .clk          ( clk            ),
      .reset        ( reset          ),
      .act_valid    ( act_valid      ),
      .act_data     ( act_word       ),
      .weight_valid ( weight_valid   ),
      .weight_byte  ( weight_word[l*accel_cfg_pkg::data_width +: accel_cfg_pkg::data_width] ),
      .slot         ( slot           ),
      .first_iter   ( first_iter     ),
      .last_iter    ( iter_last      ),
      .result       ( result[l]      ),
      .result_slot  ( result_slot[l] ),
      .sums         ( lane_sums[l]   )
    );

    output_writer i_output_writer (
      .clk           ( clk            ),
      .reset         ( reset          ),
      .start         ( start          ),
      .write_address ( write_address  ),
      .min_clip      ( min_clip       ),
      .max_clip      ( max_clip       ),
      .result        ( result[l]      ),
      .result_slot   ( result_slot[l] ),
      .sums          ( lane_sums[l]   ),
      .data          ( data[l]        ),
      .addr          ( addr[l]        ),
      .valid         ( valid[l]       )
    );
  end

endmodule

// ==== tb/accel_checker.sv ====
// #########################################################################
// output checker
// pops the expected writes of each job and compares every lane's data
// and address when the write strobes fire
// #########################################################################

module accel_checker (
  input logic                                                  clk,
  input logic                                                  reset,
  input accel_types_pkg::word_t [accel_cfg_pkg::num_lanes-1:0] data,
  input accel_types_pkg::addr_t [accel_cfg_pkg::num_lanes-1:0] addr,
  input logic [accel_cfg_pkg::num_lanes-1:0]                   valid,
  input logic                                                  busy
);

  // one entry per write cycle, all lanes share the address
  accel_types_pkg::word_t [accel_cfg_pkg::num_lanes-1:0] exp_data_q [$];
  accel_types_pkg::addr_t                                exp_addr_q [$];
  string                                                 exp_name_q [$];

  accel_types_pkg::word_t [accel_cfg_pkg::num_lanes-1:0] exp_data;
  accel_types_pkg::addr_t                                exp_addr;
  string                                                 exp_name;

  int data_errors    = 0;
  int addr_errors    = 0;
  int control_errors = 0;

  task automatic expect_write(input string name,
                              input accel_types_pkg::word_t [accel_cfg_pkg::num_lanes-1:0] d,
                              input accel_types_pkg::addr_t a);
    exp_name_q.push_back(name);
    exp_data_q.push_back(d);
    exp_addr_q.push_back(a);
  endtask

  function automatic int pending();
    return exp_addr_q.size();
  endfunction

  task automatic drop_expected();
    exp_name_q.delete();
    exp_data_q.delete();
    exp_addr_q.delete();
  endtask

  // values seen here were registered on the previous edge
  always @(posedge clk) begin
    if (!reset && valid != '0) begin
      if (valid != '1) begin
        control_errors++;
        $display("lanes wrote in different cycles, valid %b", valid);
      end
      if (!busy) begin
        control_errors++;
        $display("output write while busy is low");
      end
      if (exp_addr_q.size() == 0) begin
        control_errors++;
        $display("unexpected output write with nothing pending, addr %h", addr[0]);
      end else begin
        exp_name = exp_name_q.pop_front();
        exp_data = exp_data_q.pop_front();
        exp_addr = exp_addr_q.pop_front();
        for (int l = 0; l < accel_cfg_pkg::num_lanes; l++) begin
          if (valid[l] && data[l] !== exp_data[l]) begin
            data_errors++;
            $display("error %s lane %0d data: expected %h, actual %h",
                     exp_name, l, exp_data[l], data[l]);
          end
          if (valid[l] && addr[l] !== exp_addr) begin
            addr_errors++;
            $display("error %s lane %0d addr: expected %h, actual %h",
                     exp_name, l, exp_addr, addr[l]);
          end
        end
      end
    end
  end

endmodule

// ==== tb/accel_sva.sv ====
// #########################################################################
// accelerator strobe assertions
// lanes write together, writes only during a job, idle out of reset
// #########################################################################

module accel_sva (
  input logic                                clk,
  input logic                                reset,
  input logic [accel_cfg_pkg::num_lanes-1:0] valid,
  input logic                                busy
);

  lanes_in_step: assert property (
    @(posedge clk) disable iff (reset) (valid == '0) || (valid == '1)
  ) else $error("output lanes did not write in the same cycle, valid %b", valid);

  write_only_when_busy: assert property (
    @(posedge clk) disable iff (reset) (valid != '0) |-> busy
  ) else $error("output write seen while busy is low");

  // first edge after reset is released
  idle_out_of_reset: assert property (
    @(posedge clk) $fell(reset) |-> (!busy && valid == '0)
  ) else $error("busy or valid high right after reset");

endmodule

bind rtlinf_accel accel_sva i_accel_sva (
  .clk   ( clk   ),
  .reset ( reset ),
  .valid ( valid ),
  .busy  ( busy  )
);

// ==== tb/tb_rtlinf_accel.sv ====
// #########################################################################
// accelerator testbench
// random memory loads and jobs from a fixed seed, a shadow model that
// predicts every output write, and a cycle limit on the whole run
// #########################################################################

module tb_rtlinf_accel;

  localparam int num_jobs  = 40;
  localparam int max_iters = 8;
  localparam int dw        = accel_cfg_pkg::data_width;
  localparam int timeout_cycles = 2 * accel_cfg_pkg::mem_depth
    + num_jobs * (max_iters * (accel_cfg_pkg::max_reads + 2) + 10) + 200;

  logic clk, reset, mem_write, mem_sel, configure;
  accel_types_pkg::addr_t mem_addr, read_address, write_address;
  accel_types_pkg::word_t mem_data;
  accel_types_pkg::iter_t num_iters;
  accel_types_pkg::slot_t num_reads_per_iter;
  accel_types_pkg::elem_t min_clip, max_clip;
  accel_types_pkg::word_t [accel_cfg_pkg::num_lanes-1:0] data;
  accel_types_pkg::addr_t [accel_cfg_pkg::num_lanes-1:0] addr;
  logic [accel_cfg_pkg::num_lanes-1:0] valid;
  logic busy;

  accel_types_pkg::word_t act_shadow [accel_cfg_pkg::mem_depth];
  accel_types_pkg::word_t wt_shadow [accel_cfg_pkg::mem_depth];
  integer seed        = 75;
  int     tb_errors   = 0;
  int     cycle_count = 0;

  rtlinf_accel i_rtlinf_accel (.*);
  accel_checker i_accel_checker (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic int pick_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic write_word(input int sel, input int a, input accel_types_pkg::word_t d);
    @(posedge clk);
    mem_write <= 1'b1;
    mem_sel   <= (sel == 1);
    mem_addr  <= accel_types_pkg::addr_t'(a);
    mem_data  <= d;
    if (sel == 1) wt_shadow[a] = d;
    else act_shadow[a] = d;
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (busy !== 1'b0 || valid !== '0) begin
        tb_errors++;
        $display("busy or valid high with no job configured (busy %b, valid %b)", busy, valid);
      end
    end
  endtask

  // job rule applied to the shadow memories gives one expected write per slot
  task automatic predict_job(input string name, input int iters, input int reads,
                             input int ra, input int wa, input int lo, input int hi);
    accel_types_pkg::word_t [accel_cfg_pkg::num_lanes-1:0] expected;
    accel_types_pkg::word_t act_word;
    accel_types_pkg::word_t wt_word;
    logic [15:0] sum;
    for (int r = 0; r < reads; r++) begin
      for (int l = 0; l < accel_cfg_pkg::num_lanes; l++) begin
        for (int g = 0; g < accel_cfg_pkg::group_size; g++) begin
          sum = '0;
          for (int it = 0; it < iters; it++) begin
            act_word = act_shadow[(ra + it * reads + r) % accel_cfg_pkg::mem_depth];
            wt_word  = wt_shadow[(ra + it) % accel_cfg_pkg::mem_depth];
            sum = sum + 16'(act_word[g*dw +: dw]) * 16'(wt_word[l*dw +: dw]);  // wraps
          end
          expected[l][g*dw +: dw] = (sum < lo) ? 8'(lo) : (sum > hi) ? 8'(hi) : sum[7:0];
        end
      end
      i_accel_checker.expect_write(name, expected, accel_types_pkg::addr_t'(wa + r));
    end
  endtask

  task automatic run_job(input int job, input int iters, input int reads,
                         input int ra, input int wa, input int lo, input int hi);
    string name;
    name = $sformatf("job_%0d", job);
    predict_job(name, iters, reads, ra, wa, lo, hi);
    @(posedge clk);
    mem_write          <= 1'b0;  // last rewrite lands on this edge
    configure          <= 1'b1;
    num_iters          <= accel_types_pkg::iter_t'(iters);
    num_reads_per_iter <= accel_types_pkg::slot_t'(reads);
    read_address       <= accel_types_pkg::addr_t'(ra);
    write_address      <= accel_types_pkg::addr_t'(wa);
    min_clip           <= accel_types_pkg::elem_t'(lo);
    max_clip           <= accel_types_pkg::elem_t'(hi);
    @(posedge clk);
    configure <= 1'b0;
    @(negedge clk);
    if (!busy) begin
      tb_errors++;
      $display("%s: busy did not rise after configure", name);
    end
    if (job % 4 == 3) begin
      // second configure with other bounds while the job runs
      repeat (2) @(posedge clk);
      configure          <= 1'b1;
      num_iters          <= accel_types_pkg::iter_t'(1 + pick_below(max_iters));
      num_reads_per_iter <= accel_types_pkg::slot_t'(1 + pick_below(accel_cfg_pkg::max_reads));
      write_address      <= accel_types_pkg::addr_t'(pick_below(accel_cfg_pkg::mem_depth));
      @(posedge clk);
      configure <= 1'b0;
    end
    do @(negedge clk); while (busy);
    if (i_accel_checker.pending() != 0) begin
      tb_errors++;
      $display("%s: busy fell with %0d expected writes missing", name,
               i_accel_checker.pending());
      i_accel_checker.drop_expected();
    end
  endtask

  initial begin
    int iters, reads, ra, wa, lo, hi, a, b, total;
    reset = 1'b1;
    mem_write = 1'b0;
    mem_sel = 1'b0;
    mem_addr = '0;
    mem_data = '0;
    configure = 1'b0;
    num_iters = 8'd1;
    num_reads_per_iter = 5'd1;
    read_address = '0;
    write_address = '0;
    min_clip = '0;
    max_clip = '1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    check_idle(4);
    for (int sel = 0; sel < 2; sel++) begin
      for (int i = 0; i < accel_cfg_pkg::mem_depth; i++) write_word(sel, i, $random(seed));
    end
    for (int job = 0; job < num_jobs; job++) begin
      ra    = pick_below(accel_cfg_pkg::mem_depth);
      wa    = pick_below(accel_cfg_pkg::mem_depth);
      iters = 1 + pick_below(max_iters);
      reads = 1 + pick_below(accel_cfg_pkg::max_reads);
      if (job == 0) begin
        iters = 1;  // shortest job
        reads = 1;
      end else if (job == 1) begin
        iters = max_iters;  // longest job with both address ranges wrapping
        reads = accel_cfg_pkg::max_reads;
        ra    = accel_cfg_pkg::mem_depth - 6;
        wa    = accel_cfg_pkg::mem_depth - 3;
      end
      a  = pick_below(256);
      b  = pick_below(256);
      lo = (a < b) ? a : b;
      hi = (a < b) ? b : a;
      if (job > 0) begin
        repeat (1 + pick_below(4)) begin
          write_word(pick_below(2), pick_below(accel_cfg_pkg::mem_depth), $random(seed));
        end
        // one activation word and one weight word that this job reads
        write_word(0, (ra + pick_below(iters * reads)) % accel_cfg_pkg::mem_depth,
                   $random(seed));
        write_word(1, (ra + pick_below(iters)) % accel_cfg_pkg::mem_depth,
                   $random(seed));
      end
      run_job(job, iters, reads, ra, wa, lo, hi);
    end
    repeat (4) @(posedge clk);  // room for stray late writes
    total = tb_errors + i_accel_checker.data_errors + i_accel_checker.addr_errors
          + i_accel_checker.control_errors;
    $display("summary: data errors %0d, addr errors %0d, control errors %0d, sequencing errors %0d",
             i_accel_checker.data_errors, i_accel_checker.addr_errors,
             i_accel_checker.control_errors, tb_errors);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
source/accel_cfg_pkg.sv
source/accel_types_pkg.sv
source/operand_mem.sv
source/job_fsm.sv
source/loop_counter.sv
source/mac_lane.sv
source/output_writer.sv
source/rtlinf_accel.sv
tb/accel_checker.sv
tb/accel_sva.sv
tb/tb_rtlinf_accel.sv

// ==== Makefile ====
# Verilator build and run of the inference accelerator testbench

TOP = tb_rtlinf_accel

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee sim.log
	@if grep -q "Test failures found" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" sim.log || { echo "no pass line in sim.log"; exit 1; }

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
